// ==== source/xbar_pkg.sv ====
package xbar_pkg;

  // ------------------------------------------------------------------------
  // bus geometry
  // ------------------------------------------------------------------------
  localparam int ADDR_BITS = 19;       // external address width
  localparam int POS_BITS  = 11;       // window selector, addr[18:8]
  localparam int WORD_BITS = 16;       // bus and pattern word width

  // ------------------------------------------------------------------------
  // pattern memory and shift sequencing
  // ------------------------------------------------------------------------
  localparam int PATTERN_WORDS  = 32;  // words per controller
  localparam int INDEX_BITS     = 5;   // log2 of PATTERN_WORDS
  localparam int BIT_COUNT_BITS = 9;   // counts 512 serial bits

  // region field value that selects the command register
  localparam logic [2:0] REGION_COMMAND = 3'd1;

  // flat offsets of the read-only words
  localparam logic [7:0] REG_ID     = 8'h09;
  localparam logic [7:0] REG_STATUS = 8'h0A;

  // id word returned at REG_ID
  localparam logic [WORD_BITS-1:0] ID_VALUE = 16'h7ba2;

  // low address byte inside a controller window
  // word view for writes, flat view for register reads
  typedef union packed {
    struct packed {
      logic [2:0]            region;  // 1 is command, anything else pattern
      logic [INDEX_BITS-1:0] index;   // pattern word number
    } word;
    logic [7:0] offset;               // flat register offset
  } xbar_offset_t;

endpackage

// ==== source/xbar_regs.sv ====
module xbar_regs
  import xbar_pkg::*;
#(
  parameter int POSITION = 0  // window number, compared with addr[18:8]
) (
  input  logic                  sclk,
  input  logic                  reset,
  input  logic                  enable,       // bus enable
  input  logic                  re,           // read strobe
  input  logic                  wr,           // write strobe
  input  logic [ADDR_BITS-1:0]  addr,
  input  logic [WORD_BITS-1:0]  data,
  input  logic                  busy,         // from sequencer
  input  logic [INDEX_BITS-1:0] word_index,   // from sequencer
  output logic [WORD_BITS-1:0]  data_out,     // registered read word
  output logic                  start,        // command pending level
  output logic [WORD_BITS-1:0]  pattern_word  // memory word at word_index
);

  // ------------------------------------------------------------------------
  // select and address decode
  // ------------------------------------------------------------------------
  logic                 cs;
  xbar_offset_t         offs;
  logic [WORD_BITS-1:0] command;
  logic [WORD_BITS-1:0] status_word;

  // pattern storage, 32 x 16
  logic [WORD_BITS-1:0] pattern_mem [PATTERN_WORDS];

  // window hit on upper address bits
  assign cs = enable && (addr[ADDR_BITS-1 -: POS_BITS] == POS_BITS'(POSITION));

  assign offs = addr[7:0];  // same byte, two views

  // any nonzero command starts a cycle
  assign start = (command != '0);

  // status layout
  // bit 1 command still waiting, bit 0 sequencer running
  assign status_word = {{(WORD_BITS - 2){1'b0}}, start, busy};

  // sequencer fetch, combinational read
  assign pattern_word = pattern_mem[word_index];

  // ------------------------------------------------------------------------
  // pattern memory writes
  // ------------------------------------------------------------------------
  always_ff @(posedge sclk) begin
    if (reset) begin
      for (int w = 0; w < PATTERN_WORDS; w++) begin
        pattern_mem[w] <= '0;  // clear whole pattern
      end
    end else if (cs && wr && (offs.word.region != REGION_COMMAND)) begin
      pattern_mem[offs.word.index] <= data;  // takes effect at once
    end
  end

  // ------------------------------------------------------------------------
  // command register
  // ------------------------------------------------------------------------
  always_ff @(posedge sclk) begin
    if (reset) begin
      command <= '0;
    end else begin
      if (cs && wr && (offs.word.region == REGION_COMMAND)) begin
        command <= data;
      end
      // sequencer took it, drop the request
      // also swallows commands written mid cycle
      if (busy) begin
        command <= '0;
      end
    end
  end

  // ------------------------------------------------------------------------
  // read path, one cycle latency
  // ------------------------------------------------------------------------
  always_ff @(posedge sclk) begin
    if (reset) begin
      data_out <= '0;
    end else if (cs && re) begin
      case (offs.offset)
        REG_STATUS: data_out <= status_word;
        REG_ID:     data_out <= ID_VALUE;
        default:    data_out <= data_out;  // unmapped offset holds last word
      endcase
    end else begin
      data_out <= '0;  // idle bus, lets the top OR channels together
    end
  end

endmodule

// ==== source/xbar_shifter.sv ====
module xbar_shifter
  import xbar_pkg::*;
(
  input  logic                  sclk,
  input  logic                  reset,
  input  logic                  start,         // level, command pending
  input  logic [WORD_BITS-1:0]  pattern_word,  // word at word_index
  output logic                  busy,
  output logic [INDEX_BITS-1:0] word_index,
  output logic                  xbar_clock,    // one pulse per bit
  output logic                  pclk,          // latch strobe, active low
  output logic                  sin            // serial data to crossbar
);

  // ------------------------------------------------------------------------
  // one-hot state encoding
  // ------------------------------------------------------------------------
  localparam logic [4:0] IDLE           = 5'b00001;
  localparam logic [4:0] LOAD           = 5'b00010;
  localparam logic [4:0] PULSE_PCLK     = 5'b00100;
  localparam logic [4:0] PULSE_XBAR_CLK = 5'b01000;
  localparam logic [4:0] LOAD_SHIFT     = 5'b10000;

  // bit position inside a word
  localparam int LOW_BITS = $clog2(WORD_BITS);

  // index of final serial bit, 511
  localparam logic [BIT_COUNT_BITS-1:0] LAST_BIT =
    BIT_COUNT_BITS'(PATTERN_WORDS * WORD_BITS - 1);

  logic [4:0]                state;
  logic [4:0]                next_state;
  logic [BIT_COUNT_BITS-1:0] bit_count;
  logic [WORD_BITS-1:0]      shift_reg;
  logic                      word_done;   // last bit of current word
  logic                      last_bit;    // last bit of whole pattern

  assign word_done = &bit_count[LOW_BITS-1:0];
  assign last_bit  = (bit_count == LAST_BIT);

  // upper counter bits pick the memory word
  assign word_index = bit_count[BIT_COUNT_BITS-1 -: INDEX_BITS];

  assign sin = shift_reg[WORD_BITS-1];  // msb goes out first

  // ------------------------------------------------------------------------
  // state transitions
  // ------------------------------------------------------------------------
  always_comb begin
    next_state = state;
    case (state)
      IDLE: begin
        if (start) begin
          next_state = LOAD_SHIFT;
        end
      end
      LOAD_SHIFT: begin
        next_state = LOAD;  // word fetched, now setup
      end
      LOAD: begin
        next_state = PULSE_XBAR_CLK;  // sin settled
      end
      PULSE_XBAR_CLK: begin
        if (last_bit) begin
          next_state = PULSE_PCLK;
        end else if (word_done) begin
          next_state = LOAD_SHIFT;  // fetch next word
        end else begin
          next_state = LOAD;
        end
      end
      PULSE_PCLK: begin
        next_state = IDLE;
      end
      default: begin
        next_state = IDLE;  // recover from bad encoding
      end
    endcase
  end

  always_ff @(posedge sclk) begin
    if (reset) begin
      state <= IDLE;
    end else begin
      state <= next_state;
    end
  end

  // ------------------------------------------------------------------------
  // pin outputs, registered from next state
  // ------------------------------------------------------------------------
  // flops straight onto pins, no decode glitches
  always_ff @(posedge sclk) begin
    if (reset) begin
      busy       <= 1'b0;
      xbar_clock <= 1'b0;
      pclk       <= 1'b1;  // idle high
    end else begin
      busy       <= (next_state != IDLE);
      xbar_clock <= (next_state == PULSE_XBAR_CLK);
      pclk       <= (next_state != PULSE_PCLK);
    end
  end

  // ------------------------------------------------------------------------
  // bit counter and shift register
  // ------------------------------------------------------------------------
  always_ff @(posedge sclk) begin
    if (reset) begin
      bit_count <= '0;
    end else if (state == IDLE) begin
      bit_count <= '0;  // every cycle starts at word 0
    end else if (state == PULSE_XBAR_CLK) begin
      bit_count <= bit_count + 1'b1;  // wraps to 0 after 511
    end
  end

  always_ff @(posedge sclk) begin
    if (reset) begin
      shift_reg <= '0;  // keeps sin low out of reset
    end else if (state == LOAD_SHIFT) begin
      shift_reg <= pattern_word;
    end else if (state == PULSE_XBAR_CLK) begin
      // bit was sampled on this pulse, advance
      shift_reg <= {shift_reg[WORD_BITS-2:0], 1'b0};
    end
  end

endmodule

// ==== source/xbar_bank.sv ====
module xbar_bank
  import xbar_pkg::*;
#(
  parameter int NUM_CHANNELS   = 2,  // controllers in the bank
  parameter int FIRST_POSITION = 0   // window of channel 0
) (
  input  logic                    sclk,
  input  logic                    reset,
  input  logic                    enable,
  input  logic                    re,
  input  logic                    wr,
  input  logic [ADDR_BITS-1:0]    addr,
  input  logic [WORD_BITS-1:0]    data,
  output logic [WORD_BITS-1:0]    data_out,
  output logic [NUM_CHANNELS-1:0] xbar_clock,
  output logic [NUM_CHANNELS-1:0] pclk,
  output logic [NUM_CHANNELS-1:0] sin
);

  // ------------------------------------------------------------------------
  // per channel links between register block and sequencer
  // ------------------------------------------------------------------------
  logic [WORD_BITS-1:0]  chan_data    [NUM_CHANNELS];  // read words
  logic [WORD_BITS-1:0]  pattern_word [NUM_CHANNELS];
  logic [INDEX_BITS-1:0] word_index   [NUM_CHANNELS];
  logic [NUM_CHANNELS-1:0] start;
  logic [NUM_CHANNELS-1:0] busy;

  for (genvar g = 0; g < NUM_CHANNELS; g++) begin : g_chan
    xbar_regs #(
      .POSITION(FIRST_POSITION + g)  // consecutive windows
    ) u_regs (
      .sclk        (sclk),
      .reset       (reset),
      .enable      (enable),
      .re          (re),
      .wr          (wr),
      .addr        (addr),
      .data        (data),
      .busy        (busy[g]),
      .word_index  (word_index[g]),
      .data_out    (chan_data[g]),
      .start       (start[g]),
      .pattern_word(pattern_word[g])
    );

    xbar_shifter u_shifter (
      .sclk        (sclk),
      .reset       (reset),
      .start       (start[g]),
      .pattern_word(pattern_word[g]),
      .busy        (busy[g]),
      .word_index  (word_index[g]),
      .xbar_clock  (xbar_clock[g]),
      .pclk        (pclk[g]),
      .sin         (sin[g])
    );
  end

  // ------------------------------------------------------------------------
  // read merge
  // ------------------------------------------------------------------------
  // unselected channels drive zero, so a plain OR is enough
  always_comb begin
    data_out = '0;
    for (int c = 0; c < NUM_CHANNELS; c++) begin
      data_out = data_out | chan_data[c];
    end
  end

endmodule

// ==== verif/xbar_shifter_properties.sv ====
module xbar_shifter_properties (
  input logic       sclk,
  input logic       reset,
  input logic [4:0] state,       // sequencer one-hot state
  input logic       busy,
  input logic       xbar_clock,
  input logic       pclk
);

  localparam logic [4:0] IDLE_STATE = 5'b00001;  // one-hot idle code

  int unsigned fail_count = 0;  // read by the testbench at the end

  // ------------------------------------------------------------------------
  // pin protocol
  // ------------------------------------------------------------------------
  a_no_overlap: assert property (@(posedge sclk) disable iff (reset)
    !(xbar_clock && !pclk))
    else begin
      fail_count++;
      $error("xbar_clock high while pclk is low");
    end

  a_pclk_single: assert property (@(posedge sclk) disable iff (reset)
    $fell(pclk) |=> pclk)  // one low cycle only
    else begin
      fail_count++;
      $error("pclk stayed low for more than one cycle");
    end

  a_clock_single: assert property (@(posedge sclk) disable iff (reset)
    xbar_clock |=> !xbar_clock)
    else begin
      fail_count++;
      $error("xbar_clock high on two cycles in a row");
    end

  a_idle_not_busy: assert property (@(posedge sclk) disable iff (reset)
    (state == IDLE_STATE) |-> !busy)
    else begin
      fail_count++;
      $error("busy high while sequencer is idle");
    end

endmodule

bind xbar_shifter xbar_shifter_properties u_props (
  .sclk      (sclk),
  .reset     (reset),
  .state     (state),
  .busy      (busy),
  .xbar_clock(xbar_clock),
  .pclk      (pclk)
);

// ==== verif/tb_xbar_bank.sv ====
module tb_xbar_bank
  import xbar_pkg::*;
();

  localparam int CHANNELS       = 2;                           // dut default
  localparam int STREAM_BITS    = PATTERN_WORDS * WORD_BITS;   // 512
  localparam int PROGRAM_CYCLES = 5;                           // shift-outs run below

  logic                 sclk = 1'b0;
  logic                 reset;
  logic                 enable;
  logic                 re;
  logic                 wr;
  logic [ADDR_BITS-1:0] addr;
  logic [WORD_BITS-1:0] data;
  logic [WORD_BITS-1:0] data_out;
  logic [CHANNELS-1:0]  xbar_clock;
  logic [CHANNELS-1:0]  pclk;
  logic [CHANNELS-1:0]  sin;

  logic [31:0]            rng;                                    // xorshift state
  logic [WORD_BITS-1:0]   model_mem [CHANNELS][PATTERN_WORDS];    // expected patterns
  logic [STREAM_BITS-1:0] captured [CHANNELS] = '{default: '0};  // last 512 sin bits
  int clk_count   [CHANNELS] = '{default: 0};
  int pclk_count  [CHANNELS] = '{default: 0};
  int clk_at_pclk [CHANNELS] = '{default: 0};  // pulse count seen at latch
  int clk_base    [CHANNELS];
  int pclk_base   [CHANNELS];

  xbar_bank dut (
    .sclk      (sclk),
    .reset     (reset),
    .enable    (enable),
    .re        (re),
    .wr        (wr),
    .addr      (addr),
    .data      (data),
    .data_out  (data_out),
    .xbar_clock(xbar_clock),
    .pclk      (pclk),
    .sin       (sin)
  );

  always #4 sclk = ~sclk;  // 8 unit period

  // ------------------------------------------------------------------------
  // pin monitors, values of the cycle that just ended
  // ------------------------------------------------------------------------
  always @(posedge sclk) begin
    if (!reset) begin
      for (int c = 0; c < CHANNELS; c++) begin
        if (xbar_clock[c]) begin
          captured[c] = {captured[c][STREAM_BITS-2:0], sin[c]};  // first bit ends on top
          clk_count[c]++;
        end
        if (!pclk[c]) begin
          pclk_count[c]++;
          clk_at_pclk[c] = clk_count[c];
        end
      end
    end
  end

  initial begin
    #((PROGRAM_CYCLES * 1100 + 2000) * 8);
    $display("watchdog expired, a program cycle never finished");
    $display("*** TEST FAILED ***");
    $fatal(1, "timeout");
  end

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  // word 0 msb first, so word 0 lands in the top bits
  function automatic logic [STREAM_BITS-1:0] model_stream(input int c);
    logic [STREAM_BITS-1:0] s;
    s = '0;
    for (int w = 0; w < PATTERN_WORDS; w++) begin
      s = {s[STREAM_BITS-WORD_BITS-1:0], model_mem[c][w]};
    end
    return s;
  endfunction

  // ------------------------------------------------------------------------
  // compare tasks
  // ------------------------------------------------------------------------
  task automatic check_word(input string name, input logic [WORD_BITS-1:0] exp,
                            input logic [WORD_BITS-1:0] act);
    if (exp !== act) begin
      $display("error %s expected %h actual %h", name, exp, act);
      $display("*** TEST FAILED ***");
      $fatal(1, "word mismatch");
    end
  endtask

  task automatic check_bits(input string name, input logic [STREAM_BITS-1:0] exp,
                            input logic [STREAM_BITS-1:0] act);
    if (exp !== act) begin
      $display("error %s expected %h actual %h", name, exp, act);
      $display("*** TEST FAILED ***");
      $fatal(1, "stream mismatch");
    end
  endtask

  task automatic check_count(input string name, input int exp, input int act);
    if (exp != act) begin
      $display("error %s expected %0d actual %0d", name, exp, act);
      $display("*** TEST FAILED ***");
      $fatal(1, "count mismatch");
    end
  endtask

  // ------------------------------------------------------------------------
  // bus access, driven on the falling edge
  // ------------------------------------------------------------------------
  task automatic bus_write(input logic en, input logic [POS_BITS-1:0] pos,
                           input logic [7:0] off, input logic [WORD_BITS-1:0] d);
    @(negedge sclk);
    enable = en;
    wr     = 1'b1;
    re     = 1'b0;
    addr   = {pos, off};
    data   = d;
  endtask

  task automatic bus_idle();
    @(negedge sclk);
    enable = 1'b0;
    wr     = 1'b0;
    re     = 1'b0;
  endtask

  task automatic bus_read(input logic [POS_BITS-1:0] pos, input logic [7:0] off,
                          output logic [WORD_BITS-1:0] rd);
    @(negedge sclk);
    enable = 1'b1;
    re     = 1'b1;
    wr     = 1'b0;
    addr   = {pos, off};
    @(negedge sclk);
    enable = 1'b0;
    re     = 1'b0;
    rd     = data_out;  // registered one cycle after the strobe
  endtask

  task automatic load_pattern(input int c);
    xbar_offset_t off;
    logic [2:0]   region;
    for (int w = 0; w < PATTERN_WORDS; w++) begin
      rng    = xorshift32(rng);
      region = rng[18:16];
      if (region == REGION_COMMAND) begin
        region = 3'd6;  // any other region hits the pattern
      end
      off.word.region = region;
      off.word.index  = INDEX_BITS'(w);
      bus_write(1'b1, POS_BITS'(c), off.offset, rng[15:0]);
      model_mem[c][w] = rng[15:0];
    end
    bus_idle();
  endtask

  task automatic issue_command(input int c);
    xbar_offset_t         off;
    logic [WORD_BITS-1:0] cmd;
    rng = xorshift32(rng);
    cmd = rng[15:0];
    if (cmd == '0) begin
      cmd = 16'h0001;  // zero would not start
    end
    off.word.region = REGION_COMMAND;
    off.word.index  = rng[20:16];  // ignored inside command region
    bus_write(1'b1, POS_BITS'(c), off.offset, cmd);
  endtask

  task automatic mark_start();
    for (int c = 0; c < CHANNELS; c++) begin
      clk_base[c]  = clk_count[c];
      pclk_base[c] = pclk_count[c];
    end
  endtask

  task automatic wait_done(input int c);
    while (pclk_count[c] == pclk_base[c]) begin
      @(negedge sclk);
    end
    repeat (4) @(negedge sclk);  // settle back to idle
  endtask

  task automatic check_channel(input string name, input int c, input int cycles);
    check_count({name, " clock pulses"}, cycles * STREAM_BITS, clk_count[c] - clk_base[c]);
    check_count({name, " latch strobes"}, cycles, pclk_count[c] - pclk_base[c]);
    if (cycles != 0) begin
      check_count({name, " pulses before latch"}, STREAM_BITS, clk_at_pclk[c] - clk_base[c]);
      check_bits({name, " stream"}, model_stream(c), captured[c]);
    end
  endtask

  task automatic run_program(input int c);
    logic [WORD_BITS-1:0] rd;
    int                   other;
    other = 1 - c;
    mark_start();
    issue_command(c);
    bus_read(POS_BITS'(c), REG_STATUS, rd);  // command pending, not yet busy
    check_word("status after command", 16'h0002, rd);
    bus_read(POS_BITS'(other), REG_STATUS, rd);
    check_word("idle channel status", '0, rd);
    wait_done(c);
    bus_read(POS_BITS'(c), REG_STATUS, rd);
    check_word("status after cycle", '0, rd);
    check_channel("single program", c, 1);
    check_channel("quiet channel", other, 0);
  endtask

  // ------------------------------------------------------------------------
  // test sequence
  // ------------------------------------------------------------------------
  initial begin
    logic [WORD_BITS-1:0] rd;
    int unsigned          fails;
    rng    = 32'h17eb_dc09;
    reset  = 1'b1;
    enable = 1'b0;
    re     = 1'b0;
    wr     = 1'b0;
    addr   = '0;
    data   = '0;
    repeat (8) @(negedge sclk);
    reset = 1'b0;
    @(negedge sclk);

    check_word("reset data_out", '0, data_out);
    check_word("reset xbar_clock", '0, WORD_BITS'(xbar_clock));
    check_word("reset pclk", WORD_BITS'({CHANNELS{1'b1}}), WORD_BITS'(pclk));
    check_word("reset sin", '0, WORD_BITS'(sin));
    for (int c = 0; c < CHANNELS; c++) begin
      bus_read(POS_BITS'(c), REG_ID, rd);
      check_word("id read", ID_VALUE, rd);
    end
    bus_read(POS_BITS'(CHANNELS), REG_ID, rd);  // no channel there
    check_word("id outside bank", '0, rd);

    for (int c = 0; c < CHANNELS; c++) begin
      load_pattern(c);
      run_program(c);
    end

    // disabled and out-of-bank writes must leave channel 0 alone
    for (int i = 0; i < 8; i++) begin
      rng = xorshift32(rng);
      bus_write(1'b0, '0, {3'd0, rng[20:16]}, rng[15:0]);
      bus_write(1'b1, POS_BITS'(CHANNELS) + POS_BITS'(rng[26:24]), {3'd0, rng[20:16]},
                rng[31:16]);
    end
    bus_idle();
    run_program(0);

    // both channels back to back, plus a swallowed command
    load_pattern(0);
    load_pattern(1);
    mark_start();
    issue_command(0);
    issue_command(1);
    bus_idle();
    repeat (100) @(negedge sclk);
    issue_command(0);  // lands while busy
    bus_idle();
    wait_done(0);
    wait_done(1);
    repeat (40) @(negedge sclk);
    check_channel("concurrent ch0", 0, 1);
    check_channel("concurrent ch1", 1, 1);

    fails = dut.g_chan[0].u_shifter.u_props.fail_count +
            dut.g_chan[1].u_shifter.u_props.fail_count;
    if (fails != 0) begin
      $display("sequencer assertions failed %0d times", fails);
      $display("*** TEST FAILED ***");
      $fatal(1, "assertion failures");
    end else begin
      $display("*** TEST PASSED ***");
      $finish;
    end
  end

endmodule

// ==== all.f ====
source/xbar_pkg.sv
source/xbar_regs.sv
source/xbar_shifter.sv
source/xbar_bank.sv
verif/xbar_shifter_properties.sv
verif/tb_xbar_bank.sv

// ==== Makefile ====
TOP := tb_xbar_bank

.PHONY: lint sim clean

lint:
	verilator --lint-only -Wall --top-module xbar_bank \
		source/xbar_pkg.sv source/xbar_regs.sv \
		source/xbar_shifter.sv source/xbar_bank.sv

sim:
	verilator --binary --timing --assert --top-module $(TOP) -f all.f
	./obj_dir/V$(TOP) 2>&1 | tee sim.log
	@if grep -qF '*** TEST FAILED ***' sim.log; then \
		echo "simulation reported a failure"; exit 1; fi
	@grep -qF '*** TEST PASSED ***' sim.log || \
		(echo "simulation ended without a pass line"; exit 1)

clean:
	rm -rf obj_dir sim.log
